//--- verilog/median_filter_pkg.sv
`default_nettype none

package median_filter_pkg;

  // pixel format
  localparam int PIX_W = 8;

  typedef logic [PIX_W-1:0] pixel_t;

  // chain end values, all-ones also marks an empty slot
  localparam pixel_t PIX_MIN = '0;
  localparam pixel_t PIX_MAX = '1;

  // sorter operation
  typedef enum logic [1:0] {
    OP_HOLD  = 2'd0,
    OP_CLEAR = 2'd1,
    OP_SWAP  = 2'd2
  } sort_op_t;

  // scanner control
  typedef enum logic [2:0] {
    // wait for a stored frame
    S_IDLE  = 3'd0,
    // empty the sorter at row start
    S_CLEAR = 3'd1,
    // full window load
    S_LOAD  = 3'd2,
    // one column in, one column out
    S_SLIDE = 3'd3,
    // median to output register
    S_EMIT  = 3'd4
  } scan_state_t;

endpackage

`default_nettype wire

//--- verilog/sort_cell.sv
`default_nettype none

module sort_cell
  import median_filter_pkg::*;
(
  input  wire logic     CLK,
  input  wire logic     RST,
  input  wire sort_op_t sort_op,
  input  wire pixel_t   ins_val,
  input  wire pixel_t   del_val,
  input  wire pixel_t   lower,
  input  wire pixel_t   upper,
  output pixel_t        value
);

  pixel_t value_nxt;

  always_comb begin
    value_nxt = value;
    case (sort_op)
      OP_CLEAR: value_nxt = PIX_MAX;
      OP_SWAP: begin
        if (ins_val < del_val) begin
          // slots between insert and delete move up one place
          if (value > ins_val && value <= del_val) begin
            value_nxt = (lower > ins_val) ? lower : ins_val;
          end
        end else if (ins_val > del_val) begin
          // slots between delete and insert move down one place
          if (value < ins_val && value >= del_val) begin
            value_nxt = (upper < ins_val) ? upper : ins_val;
          end
        end
      end
      default: value_nxt = value;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      value <= PIX_MAX;
    end else begin
      value <= value_nxt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/running_sorter.sv
`default_nettype none

module running_sorter
  import median_filter_pkg::*;
#(
  parameter int WIN = 7
) (
  input  wire logic     CLK,
  input  wire logic     RST,
  input  wire sort_op_t sort_op,
  input  wire pixel_t   ins_val,
  input  wire pixel_t   del_val,
  output pixel_t        median
);

  localparam int DEPTH = WIN * WIN;
  localparam int MID   = DEPTH / 2;

  // slot 0 holds the smallest value
  pixel_t slot [DEPTH];

  for (genvar i = 0; i < DEPTH; i++) begin : g_cell
    pixel_t lower;
    pixel_t upper;

    if (i == 0) begin : g_lo_end
      assign lower = PIX_MIN;
    end else begin : g_lo
      assign lower = slot[i-1];
    end

    if (i == DEPTH - 1) begin : g_hi_end
      assign upper = PIX_MAX;
    end else begin : g_hi
      assign upper = slot[i+1];
    end

    sort_cell sort_cell_inst (
      .CLK     (CLK),
      .RST     (RST),
      .sort_op (sort_op),
      .ins_val (ins_val),
      .del_val (del_val),
      .lower   (lower),
      .upper   (upper),
      .value   (slot[i])
    );
  end

  assign median = slot[MID];

endmodule

`default_nettype wire

//--- verilog/frame_store.sv
`default_nettype none

module frame_store
  import median_filter_pkg::*;
#(
  parameter int IMG_W = 32,
  parameter int IMG_H = 32
) (
  input  wire logic                            CLK,
  input  wire logic                            RST,
  input  wire pixel_t                          din,
  input  wire logic                            in_en,
  input  wire logic                            frame_done,
  input  wire logic [$clog2(IMG_W*IMG_H)-1:0]  rd_addr,
  output pixel_t                               rd_data,
  output logic                                 frame_full
);

  localparam int DEPTH = IMG_W * IMG_H;
  localparam int AW    = $clog2(DEPTH);

  pixel_t         mem [DEPTH];
  logic [AW-1:0]  wr_addr;
  logic           wr_en;

  // pixels offered while the frame is held are dropped
  assign wr_en = in_en && !frame_full;

  // raster write pointer and frame flag
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_addr    <= '0;
      frame_full <= 1'b0;
    end else begin
      if (wr_en) begin
        if (wr_addr == AW'(DEPTH - 1)) begin
          wr_addr    <= '0;
          frame_full <= 1'b1;
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
      // scanner has emitted the whole frame
      if (frame_done) begin
        frame_full <= 1'b0;
      end
    end
  end

  // single port style memory, read data one cycle after address
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= din;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- verilog/window_scanner.sv
`default_nettype none

module window_scanner
  import median_filter_pkg::*;
#(
  parameter int IMG_W = 32,
  parameter int IMG_H = 32,
  parameter int WIN   = 7
) (
  input  wire logic                            CLK,
  input  wire logic                            RST,
  input  wire logic                            frame_full,
  output logic [$clog2(IMG_W*IMG_H)-1:0]       rd_addr,
  input  wire pixel_t                          rd_data,
  output logic                                 frame_done,
  output sort_op_t                             sort_op,
  output pixel_t                               ins_val,
  output pixel_t                               del_val,
  input  wire pixel_t                          median,
  output logic                                 out_valid,
  output pixel_t                               dout
);

  localparam int N   = WIN * WIN;
  localparam int R   = WIN / 2;
  localparam int AW  = $clog2(IMG_W * IMG_H);
  localparam int CW  = $clog2(IMG_W + IMG_H + WIN) + 1;
  localparam int RCW = $clog2(N + 2);
  localparam int IW  = $clog2(WIN + 1);
  localparam int XW  = $clog2(IMG_W + 1);
  localparam int YW  = $clog2(IMG_H + 1);

  scan_state_t          state;
  logic [XW-1:0]        x;
  logic [YW-1:0]        y;
  logic [RCW-1:0]       rc;
  logic [RCW-1:0]       rd_total;
  // window row/col of the address being issued
  logic [IW-1:0]        ir;
  logic [IW-1:0]        ic;
  // same, one cycle later when rd_data arrives
  logic [IW-1:0]        ar;
  logic [IW-1:0]        ac;
  logic                 a_vld;
  logic                 a_in;
  logic signed [CW-1:0] rd_xx;
  logic signed [CW-1:0] rd_yy;
  logic                 rd_in;
  logic                 issue;
  logic                 last_px;
  pixel_t               new_val;
  // copy of the current window, [row][col], col 0 is leftmost
  pixel_t               win [WIN][WIN];

  assign rd_total = (state == S_LOAD) ? RCW'(N) : RCW'(WIN);
  assign issue    = (state == S_LOAD || state == S_SLIDE) && rc < rd_total;

  // image coordinates of the issued window position
  assign rd_xx = CW'(x) + CW'(ic) - CW'(R);
  assign rd_yy = CW'(y) + CW'(ir) - CW'(R);
  assign rd_in = rd_xx >= 0 && rd_xx < IMG_W && rd_yy >= 0 && rd_yy < IMG_H;

  assign rd_addr = rd_in ? AW'(rd_yy * IMG_W + rd_xx) : '0;

  // padding outside the image reads as zero
  assign new_val = a_in ? rd_data : PIX_MIN;
  assign last_px = x == XW'(IMG_W - 1) && y == YW'(IMG_H - 1);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= S_IDLE;
      x          <= '0;
      y          <= '0;
      rc         <= '0;
      ir         <= '0;
      ic         <= '0;
      ar         <= '0;
      ac         <= '0;
      a_vld      <= 1'b0;
      a_in       <= 1'b0;
      sort_op    <= OP_HOLD;
      out_valid  <= 1'b0;
      frame_done <= 1'b0;
      dout       <= '0;
    end else begin
      out_valid  <= 1'b0;
      frame_done <= 1'b0;
      sort_op    <= OP_HOLD;
      a_vld      <= issue;
      a_in       <= rd_in;
      ar         <= ir;
      ac         <= ic;

      // returned pixel becomes a sorter op next cycle
      if (a_vld) begin
        sort_op <= OP_SWAP;
      end

      // step the read position, load walks rows, slide walks one column
      if (issue) begin
        if (state == S_LOAD && ic != IW'(WIN - 1)) begin
          ic <= ic + 1'b1;
        end else begin
          ir <= ir + 1'b1;
          if (state == S_LOAD) begin
            ic <= '0;
          end
        end
      end

      case (state)
        S_IDLE: begin
          // frame_done still high means the old frame flag is clearing
          if (frame_full && !frame_done) begin
            x     <= '0;
            y     <= '0;
            state <= S_CLEAR;
          end
        end
        S_CLEAR: begin
          sort_op <= OP_CLEAR;
          rc      <= '0;
          ir      <= '0;
          ic      <= '0;
          state   <= S_LOAD;
        end
        S_LOAD, S_SLIDE: begin
          rc <= rc + 1'b1;
          // last op sits on sort_op when rc reaches total+1
          if (rc == rd_total + 1'b1) begin
            state <= S_EMIT;
          end
        end
        S_EMIT: begin
          out_valid <= 1'b1;
          dout      <= median;
          if (last_px) begin
            frame_done <= 1'b1;
            state      <= S_IDLE;
          end else if (x == XW'(IMG_W - 1)) begin
            x     <= '0;
            y     <= y + 1'b1;
            state <= S_CLEAR;
          end else begin
            x     <= x + 1'b1;
            rc    <= '0;
            ir    <= '0;
            // entering column is the rightmost one
            ic    <= IW'(WIN - 1);
            state <= S_SLIDE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // sorter operands and window copy
  always_ff @(posedge CLK) begin
    if (a_vld) begin
      ins_val <= new_val;
      if (state == S_LOAD) begin
        // empty slots hold all-ones, so that is what leaves
        del_val     <= PIX_MAX;
        win[ar][ac] <= new_val;
      end else begin
        del_val <= win[ar][0];
        for (int c = 0; c < WIN - 1; c++) begin
          win[ar][c] <= win[ar][c+1];
        end
        win[ar][WIN-1] <= new_val;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/median_filter.sv
`default_nettype none

module median_filter
  import median_filter_pkg::*;
#(
  parameter int IMG_W = 32,
  parameter int IMG_H = 32,
  parameter int WIN   = 7
) (
  input  wire logic   CLK,
  input  wire logic   RST,
  input  wire pixel_t din,
  input  wire logic   in_en,
  output logic        busy,
  output logic        out_valid,
  output pixel_t      dout
);

  localparam int AW = $clog2(IMG_W * IMG_H);

  logic           frame_full;
  logic           frame_done;
  logic [AW-1:0]  rd_addr;
  pixel_t         rd_data;
  sort_op_t       sort_op;
  pixel_t         ins_val;
  pixel_t         del_val;
  pixel_t         median;

  // input is blocked while a frame is stored
  assign busy = frame_full;

  frame_store #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) frame_store_inst (
    .CLK        (CLK),
    .RST        (RST),
    .din        (din),
    .in_en      (in_en),
    .frame_done (frame_done),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .frame_full (frame_full)
  );

  window_scanner #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H),
    .WIN   (WIN)
  ) window_scanner_inst (
    .CLK        (CLK),
    .RST        (RST),
    .frame_full (frame_full),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .frame_done (frame_done),
    .sort_op    (sort_op),
    .ins_val    (ins_val),
    .del_val    (del_val),
    .median     (median),
    .out_valid  (out_valid),
    .dout       (dout)
  );

  running_sorter #(
    .WIN (WIN)
  ) running_sorter_inst (
    .CLK     (CLK),
    .RST     (RST),
    .sort_op (sort_op),
    .ins_val (ins_val),
    .del_val (del_val),
    .median  (median)
  );

endmodule

`default_nettype wire

//--- verification/median_filter_props.sv
`default_nettype none

module median_filter_props (
  input wire logic CLK,
  input wire logic RST,
  input wire logic busy,
  input wire logic out_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // every output belongs to a stored frame
  a_valid_in_frame: assert property (
    @(posedge CLK) disable iff (RST) out_valid |-> busy
  ) else $error("out_valid high while busy is low");

  // the frame is released only by its last output
  a_busy_release: assert property (
    @(posedge CLK) disable iff (RST) $fell(busy) |-> $past(out_valid)
  ) else $error("busy fell without a preceding out_valid");

  // one cycle per output pulse
  a_single_pulse: assert property (
    @(posedge CLK) disable iff (RST) out_valid |=> !out_valid
  ) else $error("out_valid high for two cycles in a row");

endmodule

`default_nettype wire

//--- verification/median_filter_tb.sv
`default_nettype none

module median_filter_tb
  import median_filter_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int IMG_W = 32;
  localparam int IMG_H = 32;
  localparam int WIN   = 7;
  localparam int R     = WIN / 2;
  localparam int MID   = (WIN * WIN) / 2;
  localparam int NPIX  = IMG_W * IMG_H;

  localparam int FEED_LIMIT = 8 * NPIX;
  localparam int OUT_LIMIT  = 64 * NPIX;
  localparam int IDLE_LIMIT = 100;

  localparam int KIND_CONST   = 0;
  localparam int KIND_RAMP    = 1;
  localparam int KIND_CHECKER = 2;
  localparam int KIND_RANDOM  = 3;

  localparam int NUM_FRAMES = 5;

  // frames in order: pattern kind, pattern value, in_en gaps
  int     tbl_kind  [NUM_FRAMES] = '{KIND_CONST, KIND_RANDOM, KIND_RAMP, KIND_CHECKER, KIND_RANDOM};
  pixel_t tbl_value [NUM_FRAMES] = '{8'd200, 8'd0, 8'd7, 8'd180, 8'd0};
  logic   tbl_gaps  [NUM_FRAMES] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1};

  logic   CLK;
  logic   RST;
  pixel_t din;
  logic   in_en;
  logic   busy;
  logic   out_valid;
  pixel_t dout;

  logic [31:0] lfsr_state;
  pixel_t      frame_px [NPIX];
  pixel_t      exp_px   [NPIX];

  median_filter median_filter_inst (
    .CLK       (CLK),
    .RST       (RST),
    .din       (din),
    .in_en     (in_en),
    .busy      (busy),
    .out_valid (out_valid),
    .dout      (dout)
  );

  bind median_filter median_filter_props median_filter_props_inst (
    .CLK       (CLK),
    .RST       (RST),
    .busy      (busy),
    .out_valid (out_valid)
  );

  initial begin
    CLK = 1'b0;
  end

  always #5 CLK = ~CLK;

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  task automatic stop_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %0t: %s mismatch, got %0d expected %0d", $time, what, got, want);
      stop_with_failure();
    end
  endtask

  task automatic build_frame(input int kind, input pixel_t value);
    logic [31:0] r;
    int x;
    int y;
    for (int p = 0; p < NPIX; p++) begin
      x = p % IMG_W;
      y = p / IMG_W;
      case (kind)
        KIND_CONST: frame_px[p] = value;
        KIND_RAMP: frame_px[p] = pixel_t'(int'(value) + x + 2 * y);
        // 4x4 blocks of value and its complement
        KIND_CHECKER: frame_px[p] = ((x / 4 + y / 4) % 2 == 0) ? value : ~value;
        default: begin
          take_bits(PIX_W, r);
          frame_px[p] = r[PIX_W-1:0];
        end
      endcase
    end
  endtask

  // zero padded median by histogram count
  task automatic compute_expected();
    int   hist [256];
    int   acc;
    int   xx;
    int   yy;
    logic found;
    for (int y = 0; y < IMG_H; y++) begin
      for (int x = 0; x < IMG_W; x++) begin
        for (int v = 0; v < 256; v++) begin
          hist[v] = 0;
        end
        for (int dy = -R; dy <= R; dy++) begin
          for (int dx = -R; dx <= R; dx++) begin
            xx = x + dx;
            yy = y + dy;
            if (xx >= 0 && xx < IMG_W && yy >= 0 && yy < IMG_H) begin
              hist[frame_px[yy * IMG_W + xx]]++;
            end else begin
              hist[0]++;
            end
          end
        end
        acc   = 0;
        found = 1'b0;
        for (int v = 0; v < 256; v++) begin
          if (!found) begin
            acc = acc + hist[v];
            if (acc > MID) begin
              exp_px[y * IMG_W + x] = pixel_t'(v);
              found = 1'b1;
            end
          end
        end
      end
    end
  endtask

  task automatic wait_until_idle(input int f);
    int guard;
    guard = 0;
    @(negedge CLK);
    while (busy) begin
      guard++;
      if (guard > IDLE_LIMIT) begin
        $display("timeout: busy never fell before frame %0d", f);
        stop_with_failure();
      end
      @(negedge CLK);
    end
  endtask

  task automatic send_frame(input int f, input logic gaps);
    int          idx;
    int          guard;
    logic        drive;
    logic [31:0] r;
    idx   = 0;
    guard = 0;
    @(posedge CLK);
    while (idx < NPIX) begin
      drive = 1'b1;
      if (gaps) begin
        take_bits(1, r);
        drive = r[0];
      end
      in_en <= drive;
      din   <= frame_px[idx];
      @(negedge CLK);
      // busy must stay low until the whole frame is in
      check_equal($sformatf("frame %0d busy before pixel %0d", f, idx), busy, 1'b0);
      @(posedge CLK);
      if (drive) begin
        idx++;
      end
      guard++;
      if (guard > FEED_LIMIT) begin
        $display("timeout: frame %0d input stalled at pixel %0d", f, idx);
        stop_with_failure();
      end
    end
  endtask

  task automatic collect_frame(input int f);
    int          cnt;
    int          guard;
    logic        first;
    logic [31:0] r;
    logic [31:0] junk;
    cnt   = 0;
    guard = 0;
    first = 1'b1;
    while (cnt < NPIX) begin
      // offered while busy, must be dropped
      take_bits(1, r);
      take_bits(PIX_W, junk);
      in_en <= r[0];
      din   <= junk[PIX_W-1:0];
      @(negedge CLK);
      if (first) begin
        check_equal($sformatf("frame %0d busy after last pixel", f), busy, 1'b1);
        first = 1'b0;
      end
      if (out_valid) begin
        check_equal($sformatf("frame %0d dout at x %0d y %0d", f, cnt % IMG_W, cnt / IMG_W),
                    dout, exp_px[cnt]);
        cnt++;
      end
      guard++;
      if (guard > OUT_LIMIT) begin
        $display("timeout: frame %0d stopped after %0d outputs", f, cnt);
        stop_with_failure();
      end
      @(posedge CLK);
    end
    in_en <= 1'b0;
    @(negedge CLK);
    check_equal($sformatf("frame %0d busy after last output", f), busy, 1'b0);
  endtask

  initial begin
    RST        = 1'b1;
    in_en      = 1'b0;
    din        = '0;
    lfsr_state = 32'h3a30_4f96;

    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    @(negedge CLK);
    check_equal("busy after reset", busy, 1'b0);
    check_equal("out_valid after reset", out_valid, 1'b0);
    check_equal("dout after reset", dout, '0);

    for (int f = 0; f < NUM_FRAMES; f++) begin
      build_frame(tbl_kind[f], tbl_value[f]);
      compute_expected();
      wait_until_idle(f);
      send_frame(f, tbl_gaps[f]);
      collect_frame(f);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
verilog/median_filter_pkg.sv
verilog/sort_cell.sv
verilog/running_sorter.sv
verilog/frame_store.sv
verilog/window_scanner.sv
verilog/median_filter.sv
verification/median_filter_props.sv
verification/median_filter_tb.sv

//--- run.sh
#!/bin/sh
# build and run the median filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module median_filter_tb -Mdir obj_dir -f tb.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vmedian_filter_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
